// ==== include/disk_match_consts.svh ====
`ifndef DISK_MATCH_CONSTS_SVH
`define DISK_MATCH_CONSTS_SVH

// matching cuts for the inner (PS) disk modules
`define DM_RCUT         32
`define DM_PHICUT       467281
`define DM_R_OFFSET     512

// stub word field widths
`define DM_PHI_W        14
`define DM_Z_W          7
`define DM_R_W          12
`define DM_STUB_IDX_W   6

// projection word field widths, phi and r shared with the stub
`define DM_PHI_DER_W    6
`define DM_R_DER_W      8
`define DM_PROJ_IDX_W   10
`define DM_ORIGIN_W     2

`define DM_DTC_INDEX    3'b010
`define DM_EMPTY_PROJ   6'h3f
`define DM_RESID_LAT    5

`endif

// ==== hdl/disk_match_pkg.sv ====
`include "disk_match_consts.svh"

package disk_match_pkg;

    // stub: phi [13:0], z [20:14], r [32:21], stub index [38:33]
    // phi and r unsigned, z signed
    typedef logic [`DM_STUB_IDX_W+`DM_R_W+`DM_Z_W+`DM_PHI_W-1:0] stub_word_t;

    // projection: phi [13:0], r [25:14], phi der [31:26], r der [39:32],
    // proj index [49:40], origin [51:50]; both derivatives signed
    typedef logic [`DM_ORIGIN_W+`DM_PROJ_IDX_W+`DM_R_DER_W+`DM_PHI_DER_W
                   +`DM_R_W+`DM_PHI_W-1:0] proj_word_t;

    typedef logic signed [17:0]              r_resid_t;
    typedef logic signed [21:0]              phi_resid_t;
    typedef logic [35:0]                     phi_metric_t;
    typedef logic [`DM_PROJ_IDX_W-1:0]       proj_index_t;
    typedef logic [`DM_ORIGIN_W-1:0]         origin_t;

    // low to high: r resid [8:0], phi resid [20:9], dtc + stub index [29:21],
    // proj index [39:30]
    typedef logic [39:0]                     match_word_t;

    typedef enum logic {
        sel_idle,
        sel_group
    } sel_state_t;

    localparam origin_t ORIGIN_NONE    = 2'b00;
    localparam origin_t ORIGIN_PLUS    = 2'b01;
    localparam origin_t ORIGIN_MINUS   = 2'b10;
    localparam origin_t ORIGIN_CENTRAL = 2'b11;

endpackage

// ==== hdl/match_residual_calc.sv ====
`timescale 1ns/1ps
`include "disk_match_consts.svh"

module match_residual_calc
    import disk_match_pkg::*;
(
    input  logic                      clk,
    input  logic                      rst_pipe,
    input  logic                      cand_valid,
    input  logic                      event_end,
    input  stub_word_t                stub_word,
    input  proj_word_t                proj_word,
    output logic                      res_valid,
    output logic                      res_end,
    output r_resid_t                  r_resid,
    output phi_resid_t                phi_resid,
    output phi_metric_t               phi_metric,
    output logic [`DM_STUB_IDX_W-1:0] stub_index,
    output proj_index_t               proj_index,
    output origin_t                   origin
);

    // stage 1, unpacked fields
    logic [`DM_PHI_W-1:0]            s1_stub_phi;
    logic signed [`DM_Z_W-1:0]       s1_stub_z;
    logic [`DM_R_W-1:0]              s1_stub_r;
    logic [`DM_PHI_W-1:0]            s1_proj_phi;
    logic [`DM_R_W-1:0]              s1_proj_r;
    logic signed [`DM_PHI_DER_W-1:0] s1_phi_der;
    logic signed [`DM_R_DER_W-1:0]   s1_r_der;

    // stage 2, raw differences and z terms
    logic signed [12:0] s2_r_diff;
    logic signed [14:0] s2_phi_diff;
    // products sized so the multiply cannot wrap
    logic signed [14:0] s2_r_der_term;
    logic signed [12:0] s2_phi_der_term;
    logic [12:0]        s2_r_off;

    // stages 3 and 4
    r_resid_t    s3_r_res;
    phi_resid_t  s3_phi_res;
    logic [12:0] s3_r_off;
    r_resid_t    s4_r_res;
    phi_resid_t  s4_phi_res;
    logic [21:0] s4_phi_abs;
    logic [12:0] s4_r_off;

    // side delay line
    logic [`DM_RESID_LAT-1:0]  valid_sr;
    logic [`DM_RESID_LAT-1:0]  end_sr;
    logic [`DM_STUB_IDX_W-1:0] stub_idx_sr [`DM_RESID_LAT];
    proj_index_t               proj_idx_sr [`DM_RESID_LAT];
    origin_t                   origin_sr   [`DM_RESID_LAT];

    ////////////////////////////////
    // arithmetic
    ////////////////////////////////
    always_ff @(posedge clk) begin
        s1_stub_phi <= stub_word[13:0];
        s1_stub_z   <= stub_word[20:14];
        s1_stub_r   <= stub_word[32:21];
        s1_proj_phi <= proj_word[13:0];
        s1_proj_r   <= proj_word[25:14];
        s1_phi_der  <= proj_word[31:26];
        s1_r_der    <= proj_word[39:32];

        s2_r_diff       <= $signed({1'b0, s1_stub_r}) - $signed({1'b0, s1_proj_r});
        s2_phi_diff     <= $signed({1'b0, s1_stub_phi}) - $signed({1'b0, s1_proj_phi});
        s2_r_der_term   <= (s1_stub_z * s1_r_der) >>> 5;
        s2_phi_der_term <= (s1_stub_z * s1_phi_der) >>> 2;
        s2_r_off        <= s1_stub_r + `DM_R_OFFSET;

        s3_r_res   <= s2_r_diff - s2_r_der_term;
        s3_phi_res <= s2_phi_diff - s2_phi_der_term;
        s3_r_off   <= s2_r_off;

        s4_r_res   <= s3_r_res;
        s4_phi_res <= s3_phi_res;
        s4_phi_abs <= s3_phi_res[21] ? -s3_phi_res : s3_phi_res;
        s4_r_off   <= s3_r_off;

        // phi residual scaled by the offset radius
        r_resid    <= s4_r_res;
        phi_resid  <= s4_phi_res;
        phi_metric <= s4_phi_abs * s4_r_off;
    end

    ////////////////////////////////
    // indices and strobes
    ////////////////////////////////
    always_ff @(posedge clk) begin
        stub_idx_sr[0] <= stub_word[38:33];
        proj_idx_sr[0] <= proj_word[49:40];
        origin_sr[0]   <= proj_word[51:50];
        for (int i = 1; i < `DM_RESID_LAT; i++) begin
            stub_idx_sr[i] <= stub_idx_sr[i-1];
            proj_idx_sr[i] <= proj_idx_sr[i-1];
            origin_sr[i]   <= origin_sr[i-1];
        end
    end

    always_ff @(posedge clk) begin
        if (rst_pipe) begin
            valid_sr <= '0;
            end_sr   <= '0;
        end else begin
            valid_sr <= {valid_sr[`DM_RESID_LAT-2:0], cand_valid};
            end_sr   <= {end_sr[`DM_RESID_LAT-2:0], event_end};
        end
    end

    assign res_valid  = valid_sr[`DM_RESID_LAT-1];
    assign res_end    = end_sr[`DM_RESID_LAT-1];
    assign stub_index = stub_idx_sr[`DM_RESID_LAT-1];
    assign proj_index = proj_idx_sr[`DM_RESID_LAT-1];
    assign origin     = origin_sr[`DM_RESID_LAT-1];

endmodule

// ==== hdl/best_match_select.sv ====
`timescale 1ns/1ps
`include "disk_match_consts.svh"

module best_match_select
    import disk_match_pkg::*;
(
    input  logic                      clk,
    input  logic                      rst_pipe,
    input  logic                      res_valid,
    input  logic                      res_end,
    input  r_resid_t                  r_resid,
    input  phi_resid_t                phi_resid,
    input  phi_metric_t               phi_metric,
    input  logic [`DM_STUB_IDX_W-1:0] stub_index,
    input  proj_index_t               proj_index,
    input  origin_t                   origin,
    output match_word_t               match_word,
    output logic                      valid_central,
    output logic                      valid_plus,
    output logic                      valid_minus
);

    sel_state_t  state;
    sel_state_t  state_nxt;

    // open group
    proj_index_t cur_index;
    origin_t     cur_origin;
    phi_metric_t best_metric;
    match_word_t best_word;
    logic        best_found;

    proj_index_t index_nxt;
    origin_t     origin_nxt;
    phi_metric_t metric_nxt;
    match_word_t word_nxt;
    logic        found_nxt;

    // candidate evaluation
    logic        key_match;
    logic [17:0] r_abs;
    phi_metric_t ref_metric;
    logic        cand_ok;
    match_word_t cand_word;

    // closing group result
    logic        close_valid;
    match_word_t close_word;
    origin_t     close_origin;

    // registered winner, one cycle before the pulse
    logic        win_valid_q;
    match_word_t win_word_q;
    origin_t     win_origin_q;

    assign key_match = (state == sel_group) && (proj_index == cur_index)
                       && (origin == cur_origin);
    assign r_abs     = r_resid[17] ? -r_resid : r_resid;

    // a new group starts from the phi cut
    assign ref_metric = key_match ? best_metric : phi_metric_t'(`DM_PHICUT);
    assign cand_ok    = (r_abs < `DM_RCUT) && (phi_metric < ref_metric)
                        && (proj_index[5:0] != `DM_EMPTY_PROJ);
    assign cand_word  = {proj_index, `DM_DTC_INDEX, stub_index, phi_resid[11:0], r_resid[8:0]};

    ////////////////////////////////
    // group tracking
    ////////////////////////////////
    always_comb begin
        state_nxt    = state;
        index_nxt    = cur_index;
        origin_nxt   = cur_origin;
        metric_nxt   = best_metric;
        word_nxt     = best_word;
        found_nxt    = best_found;
        close_valid  = 1'b0;
        close_word   = best_word;
        close_origin = cur_origin;

        if (res_valid && !key_match) begin
            // new key, the running group ends and this one opens
            close_valid = (state == sel_group) && best_found;
            state_nxt   = sel_group;
            index_nxt   = proj_index;
            origin_nxt  = origin;
            found_nxt   = cand_ok;
            metric_nxt  = cand_ok ? phi_metric : phi_metric_t'(`DM_PHICUT);
            word_nxt    = cand_word;
        end else if (res_valid && cand_ok) begin
            // strictly smaller only, so a tie keeps the earlier one
            found_nxt  = 1'b1;
            metric_nxt = phi_metric;
            word_nxt   = cand_word;
        end

        // end of event closes the group including a candidate in this cycle;
        // it is expected alone or on the last candidate of the running group
        if (res_end) begin
            close_valid  = (state_nxt == sel_group) && found_nxt;
            close_word   = word_nxt;
            close_origin = origin_nxt;
            state_nxt    = sel_idle;
        end
    end

    always_ff @(posedge clk) begin
        if (rst_pipe) begin
            state      <= sel_idle;
            best_found <= 1'b0;
        end else begin
            state      <= state_nxt;
            best_found <= found_nxt;
        end
    end

    always_ff @(posedge clk) begin
        cur_index   <= index_nxt;
        cur_origin  <= origin_nxt;
        best_metric <= metric_nxt;
        best_word   <= word_nxt;
    end

    ////////////////////////////////
    // output routing
    ////////////////////////////////
    always_ff @(posedge clk) begin
        if (rst_pipe) begin
            win_valid_q   <= 1'b0;
            valid_central <= 1'b0;
            valid_plus    <= 1'b0;
            valid_minus   <= 1'b0;
        end else begin
            win_valid_q   <= close_valid && (close_origin != ORIGIN_NONE);
            valid_central <= win_valid_q && (win_origin_q == ORIGIN_CENTRAL);
            valid_plus    <= win_valid_q && (win_origin_q == ORIGIN_PLUS);
            valid_minus   <= win_valid_q && (win_origin_q == ORIGIN_MINUS);
        end
    end

    // word lines up with the pulse
    always_ff @(posedge clk) begin
        win_word_q   <= close_word;
        win_origin_q <= close_origin;
        match_word   <= win_word_q;
    end

endmodule

// ==== hdl/disk_match_top.sv ====
`timescale 1ns/1ps
`include "disk_match_consts.svh"

module disk_match_top
    import disk_match_pkg::*;
(
    input  logic        clk,
    input  logic        rst_pipe,
    input  logic        cand_valid,
    input  stub_word_t  stub_word,
    input  proj_word_t  proj_word,
    input  logic        event_end,
    output match_word_t match_word,
    output logic        valid_central,
    output logic        valid_plus,
    output logic        valid_minus
);

    // residual pipeline to selector
    logic                      res_valid;
    logic                      res_end;
    r_resid_t                  r_resid;
    phi_resid_t                phi_resid;
    phi_metric_t               phi_metric;
    logic [`DM_STUB_IDX_W-1:0] stub_index;
    proj_index_t               proj_index;
    origin_t                   origin;

    match_residual_calc resid_i (
        .clk        (clk),
        .rst_pipe   (rst_pipe),
        .cand_valid (cand_valid),
        .event_end  (event_end),
        .stub_word  (stub_word),
        .proj_word  (proj_word),
        .res_valid  (res_valid),
        .res_end    (res_end),
        .r_resid    (r_resid),
        .phi_resid  (phi_resid),
        .phi_metric (phi_metric),
        .stub_index (stub_index),
        .proj_index (proj_index),
        .origin     (origin)
    );

    best_match_select select_i (
        .clk           (clk),
        .rst_pipe      (rst_pipe),
        .res_valid     (res_valid),
        .res_end       (res_end),
        .r_resid       (r_resid),
        .phi_resid     (phi_resid),
        .phi_metric    (phi_metric),
        .stub_index    (stub_index),
        .proj_index    (proj_index),
        .origin        (origin),
        .match_word    (match_word),
        .valid_central (valid_central),
        .valid_plus    (valid_plus),
        .valid_minus   (valid_minus)
    );

endmodule

// ==== dv/disk_match_chk.sv ====
`timescale 1ns/1ps
`include "disk_match_consts.svh"

module disk_match_chk (
    input logic clk,
    input logic rst_pipe,
    input logic cand_valid,
    input logic event_end,
    input logic valid_central,
    input logic valid_plus,
    input logic valid_minus
);

    logic any_valid;
    // failed assertion count
    int   fail_count = 0;

    assign any_valid = valid_central | valid_plus | valid_minus;

    ////////////////////////////////
    // output pulse rules
    ////////////////////////////////
    onehot_pulse_a: assert property (@(posedge clk) disable iff (rst_pipe)
        $onehot0({valid_central, valid_plus, valid_minus}))
    else begin
        $error("more than one output pulse high in one cycle");
        fail_count++;
    end

    // pulses clear on the reset edge and the win register keeps them low one more cycle
    reset_quiet_a: assert property (@(posedge clk) rst_pipe |=> (!any_valid) [*2])
    else begin
        $error("output pulse during or right after reset");
        fail_count++;
    end

    latency_a: assert property (@(posedge clk) disable iff (rst_pipe)
        any_valid |-> $past(cand_valid || event_end, `DM_RESID_LAT + 2))
    else begin
        $error("output pulse without a closing input at the expected latency");
        fail_count++;
    end

endmodule

bind disk_match_top disk_match_chk chk_i (
    .clk           (clk),
    .rst_pipe      (rst_pipe),
    .cand_valid    (cand_valid),
    .event_end     (event_end),
    .valid_central (valid_central),
    .valid_plus    (valid_plus),
    .valid_minus   (valid_minus)
);

// ==== dv/disk_match_tb.sv ====
`timescale 1ns/1ps
`include "disk_match_consts.svh"

module disk_match_tb
    import disk_match_pkg::*;
;

    localparam int K_CAND = 0;
    localparam int K_END  = 1;
    localparam int K_IDLE = 2;
    localparam int K_RST  = 3;

    typedef struct {
        int          test;
        int          kind;
        int          gap;
        logic [13:0] sphi;
        logic [6:0]  z;
        logic [11:0] sr;
        logic [5:0]  sidx;
        logic [13:0] pphi;
        logic [11:0] pr;
        logic [5:0]  pder;
        logic [7:0]  rder;
        proj_index_t pidx;
        origin_t     org;
    } entry_t;

    logic        clk;
    logic        rst_pipe;
    logic        cand_valid;
    logic        event_end;
    stub_word_t  stub_word;
    proj_word_t  proj_word;
    match_word_t match_word;
    logic        valid_central;
    logic        valid_plus;
    logic        valid_minus;

    entry_t      stim_q [$];
    match_word_t exp_word_q [$];
    origin_t     exp_org_q [$];
    int          exp_cyc_q [$];

    // reference model group state
    logic        m_open;
    logic        m_found;
    proj_index_t m_pidx;
    origin_t     m_org;
    longint      m_best;
    match_word_t m_word;

    int          errors;
    int          checks;
    int          tests_run;
    int          err_before;
    int          assert_seen;
    int          cyc_count;
    integer      seed;
    origin_t     got_org;

    disk_match_top dut_i (
        .clk           (clk),
        .rst_pipe      (rst_pipe),
        .cand_valid    (cand_valid),
        .stub_word     (stub_word),
        .proj_word     (proj_word),
        .event_end     (event_end),
        .match_word    (match_word),
        .valid_central (valid_central),
        .valid_plus    (valid_plus),
        .valid_minus   (valid_minus)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    always @(posedge clk) begin
        cyc_count++;
    end

    task automatic compare(input logic [39:0] got, input logic [39:0] exp, input string what);
        checks++;
        if (got !== exp) begin
            $display("Fail at %0t: %s is %h, expected %h", $time, what, got, exp);
            errors++;
        end
    endtask

    ////////////////////////////////
    // stimulus table
    ////////////////////////////////
    task automatic add_cand(input int test, input logic [13:0] sphi, input logic [6:0] z,
                            input logic [11:0] sr, input logic [5:0] sidx,
                            input logic [13:0] pphi, input logic [11:0] pr,
                            input logic [5:0] pder, input logic [7:0] rder,
                            input proj_index_t pidx, input origin_t org);
        entry_t e;
        e      = '{default: 0};
        e.test = test;
        e.kind = K_CAND;
        e.sphi = sphi;
        e.z    = z;
        e.sr   = sr;
        e.sidx = sidx;
        e.pphi = pphi;
        e.pr   = pr;
        e.pder = pder;
        e.rder = rder;
        e.pidx = pidx;
        e.org  = org;
        stim_q.push_back(e);
    endtask

    task automatic add_ctrl(input int test, input int kind, input int gap);
        entry_t e;
        e      = '{default: 0};
        e.test = test;
        e.kind = kind;
        e.gap  = gap;
        stim_q.push_back(e);
    endtask

    task automatic build_table();
        // test sphi z sr sidx pphi pr pder rder pidx org
        add_cand(1, 1010, 7'h78, 120, 5, 1000, 110, 6'd3, 8'd20, 10'h012, 2'b11);
        add_ctrl(1, K_END, 0);
        // equal magnitudes on sidx 3 and 4
        add_cand(2, 2300, 0, 100, 1, 2000, 100, 0, 0, 10'h020, 2'b11);
        add_cand(2, 2100, 0, 100, 2, 2000, 100, 0, 0, 10'h020, 2'b11);
        add_cand(2, 1950, 0, 100, 3, 2000, 100, 0, 0, 10'h020, 2'b11);
        add_cand(2, 2050, 0, 100, 4, 2000, 100, 0, 0, 10'h020, 2'b11);
        add_cand(2, 2200, 0, 100, 5, 2000, 100, 0, 0, 10'h020, 2'b11);
        add_ctrl(2, K_END, 0);
        // r cut edge on both signs, a phi cut failure alone, then an empty projection
        add_cand(3, 3001, 0, 132, 1, 3000, 100, 0, 0, 10'h030, 2'b01);
        add_cand(3, 3002, 0, 68, 6, 3000, 100, 0, 0, 10'h030, 2'b01);
        add_cand(3, 3400, 0, 69, 3, 3000, 100, 0, 0, 10'h030, 2'b01);
        add_cand(3, 3500, 0, 100, 4, 3000, 100, 0, 0, 10'h030, 2'b01);
        add_cand(3, 3800, 0, 100, 2, 3000, 100, 0, 0, 10'h031, 2'b01);
        add_cand(3, 3000, 0, 100, 5, 3000, 100, 0, 0, 10'h13f, 2'b11);
        add_ctrl(3, K_END, 0);
        add_cand(4, 4010, 0, 100, 1, 4000, 100, 0, 0, 10'h040, 2'b11);
        add_cand(4, 4020, 0, 100, 2, 4000, 100, 0, 0, 10'h040, 2'b01);
        add_cand(4, 4030, 0, 100, 3, 4000, 100, 0, 0, 10'h040, 2'b10);
        add_cand(4, 4040, 0, 100, 4, 4000, 100, 0, 0, 10'h040, 2'b00);
        add_ctrl(4, K_END, 0);
        for (int i = 0; i < 6; i++) begin
            add_cand(5, 5000 + ($random(seed) % 200), 0, 100, $random(seed), 5000, 100, 0, 0,
                     10'h050 + i, (i % 3 == 0) ? 2'b11 : ((i % 3 == 1) ? 2'b01 : 2'b10));
        end
        add_ctrl(5, K_END, 0);
        // group left open when reset hits
        add_cand(6, 6005, 0, 100, 7, 6000, 100, 0, 0, 10'h060, 2'b11);
        add_ctrl(6, K_IDLE, 10);
        add_ctrl(6, K_RST, 0);
        add_cand(6, 6007, 0, 100, 8, 6000, 100, 0, 0, 10'h061, 2'b10);
        add_ctrl(6, K_END, 0);
    endtask

    ////////////////////////////////
    // reference model
    ////////////////////////////////
    task automatic close_group();
        if (m_open && m_found && (m_org != ORIGIN_NONE)) begin
            exp_word_q.push_back(m_word);
            exp_org_q.push_back(m_org);
            exp_cyc_q.push_back(cyc_count + `DM_RESID_LAT + 2);
        end
        m_open  = 1'b0;
        m_found = 1'b0;
    endtask

    task automatic model_step(input entry_t e);
        int     r_res;
        int     phi_res;
        longint metric;
        logic   same_key;
        if (e.kind == K_RST) begin
            m_open  = 1'b0;
            m_found = 1'b0;
        end else if (e.kind == K_END) begin
            close_group();
        end else if (e.kind == K_CAND) begin
            r_res   = int'(e.sr) - int'(e.pr)
                      - ((int'($signed(e.z)) * int'($signed(e.rder))) >>> 5);
            phi_res = int'(e.sphi) - int'(e.pphi)
                      - ((int'($signed(e.z)) * int'($signed(e.pder))) >>> 2);
            metric  = longint'(phi_res < 0 ? -phi_res : phi_res)
                      * (int'(e.sr) + `DM_R_OFFSET);
            same_key = m_open && (e.pidx == m_pidx) && (e.org == m_org);
            if (!same_key) begin
                close_group();
                m_open = 1'b1;
                m_pidx = e.pidx;
                m_org  = e.org;
                m_best = `DM_PHICUT;
            end
            if ((r_res < `DM_RCUT) && (r_res > -`DM_RCUT) && (metric < m_best)
                    && (e.pidx[5:0] != `DM_EMPTY_PROJ)) begin
                m_best  = metric;
                m_found = 1'b1;
                m_word  = {e.pidx, `DM_DTC_INDEX, e.sidx, phi_res[11:0], r_res[8:0]};
            end
        end
    endtask

    ////////////////////////////////
    // driving
    ////////////////////////////////
    task automatic go_idle();
        @(posedge clk);
        #1;
        cand_valid = 1'b0;
        event_end  = 1'b0;
        rst_pipe   = 1'b0;
    endtask

    task automatic apply_entry(input entry_t e);
        if (e.kind == K_IDLE) begin
            for (int i = 0; i < e.gap; i++) begin
                go_idle();
            end
        end else begin
            @(posedge clk);
            #1;
            cand_valid = (e.kind == K_CAND);
            event_end  = (e.kind == K_END);
            rst_pipe   = (e.kind == K_RST);
            stub_word  = {e.sidx, e.sr, e.z, e.sphi};
            proj_word  = {e.org, e.pidx, e.rder, e.pder, e.pr, e.pphi};
        end
        // model runs in the cycle the entry is driven
        model_step(e);
    endtask

    task automatic drain(input int test);
        int wait_cnt;
        go_idle();
        wait_cnt = 0;
        while (exp_word_q.size() > 0 && wait_cnt < 40) begin
            @(posedge clk);
            wait_cnt++;
        end
        if (exp_word_q.size() > 0) begin
            $display("test %0d: %0d expected matches never arrived", test, exp_word_q.size());
            errors += exp_word_q.size();
            exp_word_q.delete();
            exp_org_q.delete();
            exp_cyc_q.delete();
        end
        // quiet period so stray pulses are seen
        for (int i = 0; i < 10; i++) begin
            @(posedge clk);
        end
    endtask

    // outputs settle after the rising edge
    always @(negedge clk) begin
        if (valid_central || valid_plus || valid_minus) begin
            got_org = {valid_central | valid_minus, valid_central | valid_plus};
            if (exp_word_q.size() == 0) begin
                $display("Fail at %0t: output pulse arrived with no match expected", $time);
                errors++;
            end else begin
                compare(match_word, exp_word_q.pop_front(), "match word");
                compare(got_org, exp_org_q.pop_front(), "origin pulse");
                compare(cyc_count, exp_cyc_q.pop_front(), "arrival cycle");
            end
        end
    end

    initial begin
        seed        = 32'ha5ba;
        errors      = 0;
        checks      = 0;
        tests_run   = 0;
        assert_seen = 0;
        cyc_count   = 0;
        m_open      = 1'b0;
        m_found     = 1'b0;
        rst_pipe    = 1'b1;
        cand_valid  = 1'b0;
        event_end   = 1'b0;
        stub_word   = '0;
        proj_word   = '0;
        build_table();
        repeat (3) @(posedge clk);
        #1;
        rst_pipe   = 1'b0;
        err_before = 0;
        for (int i = 0; i < stim_q.size(); i++) begin
            apply_entry(stim_q[i]);
            if (i == stim_q.size() - 1 || stim_q[i+1].test != stim_q[i].test) begin
                drain(stim_q[i].test);
                tests_run++;
                errors      += dut_i.chk_i.fail_count - assert_seen;
                assert_seen  = dut_i.chk_i.fail_count;
                if (errors == err_before) begin
                    $display("test %0d ok", stim_q[i].test);
                end else begin
                    $display("test %0d failed with %0d errors", stim_q[i].test,
                             errors - err_before);
                end
                err_before = errors;
            end
        end
        $display("%0d tests, %0d checks, %0d errors", tests_run, checks, errors);
        if (errors == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule

// ==== sources.f ====
+incdir+include
hdl/disk_match_pkg.sv
hdl/match_residual_calc.sv
hdl/best_match_select.sv
hdl/disk_match_top.sv
dv/disk_match_chk.sv
dv/disk_match_tb.sv
